// File: include/wb_params.svh
/*
 * Wishbone memory block parameters.
 * Bus widths and the memory map of the two on-chip RAM regions.
 */
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// ==================================================
// Bus widths
// ==================================================

`define WB_AW 32                   // Byte address width.
`define WB_DW 32                   // Data width, select is WB_DW/8.

// ==================================================
// Memory map
// ==================================================

// RAM0 holds 512 words, 2 KB from address zero.
`define RAM0_BASE       32'h0000_0000  // Byte base of RAM0.
`define RAM0_WORDS_LOG2 9              // 512 words.

// RAM1 holds 256 words, 1 KB.
// The range 0x800 to 0xFFF between the regions is unmapped.
`define RAM1_BASE       32'h0000_1000  // Byte base of RAM1.
`define RAM1_WORDS_LOG2 8              // 256 words.

`endif

// File: hw/wb_pkg.sv
/*
 * Wishbone bundle types.
 * Request and response structs shared by the decoder and the RAM slaves.
 */
`include "wb_params.svh"

package wb_pkg;

  // ==================================================
  // Master to slave
  // ==================================================

  typedef struct packed {
    logic                  cyc;    // Bus cycle in progress.
    logic                  stb;    // Transfer strobe.
    logic                  we;     // Write when high.
    logic [`WB_AW-1:0]     adr;    // Byte address.
    logic [`WB_DW/8-1:0]   sel;    // Byte selects.
    logic [`WB_DW-1:0]     dat;    // Write data.
  } wb_req_t;                      // 71 bits.

  // ==================================================
  // Slave to master
  // ==================================================

  typedef struct packed {
    logic                  ack;    // Normal termination.
    logic                  err;    // Error termination.
    logic [`WB_DW-1:0]     dat;    // Read data.
  } wb_rsp_t;                      // 34 bits.

endpackage

// File: hw/sram_sp_be.sv
/*
 * Single-port synchronous SRAM.
 * Byte write enables, registered read data with read-before-write.
 */
module sram_sp_be #(
  parameter int WIDTH      = 32,   // Word width, multiple of 8.
  parameter int DEPTH_LOG2 = 9     // Words as a power of two.
) (
  input  logic                  wb_clk_i,
  input  logic                  en_i,     // Access enable.
  input  logic                  we_i,     // Write enable.
  input  logic [WIDTH/8-1:0]    be_i,     // Byte enables.
  input  logic [DEPTH_LOG2-1:0] adr_i,    // Word index.
  input  logic [WIDTH-1:0]      dat_i,    // Write data.
  output logic [WIDTH-1:0]      dat_o     // Read data.
);

  localparam int NBYTES = WIDTH / 8;

  logic [WIDTH-1:0] mem [0:(1 << DEPTH_LOG2) - 1];  // Storage array.

  // ==================================================
  // Write port
  // ==================================================

  always_ff @(posedge wb_clk_i) begin
    if (en_i && we_i) begin
      for (int b = 0; b < NBYTES; b++) begin
        if (be_i[b]) begin
          mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];  // Selected byte only.
        end
      end
    end
  end

  // Old word is returned on a write cycle.
  always_ff @(posedge wb_clk_i) begin
    if (en_i) begin
      dat_o <= mem[adr_i];                           // Registered read.
    end
  end

endmodule

// File: hw/wb_ram.sv
/*
 * Wishbone RAM slave.
 * Maps classic single-beat cycles onto a byte-enabled SRAM.
 * Acknowledges one clock after the strobe, never faults.
 */
`include "wb_params.svh"

module wb_ram
  import wb_pkg::*;
#(
  parameter int WORDS_LOG2 = 9     // Depth as a power of two.
) (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  wb_req_t wb_req_i,        // Request from the decoder.
  output wb_rsp_t wb_rsp_o         // Response to the decoder.
);

  // ==================================================
  // Request qualification
  // ==================================================

  logic                  ack_q;    // Acknowledge register.
  logic                  new_req;  // Strobe not yet served.
  logic [WORDS_LOG2-1:0] word_idx; // Word index into the SRAM.
  logic [`WB_DW-1:0]     mem_rdata;

  // A strobe held through ack is not served twice.
  assign new_req  = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign word_idx = wb_req_i.adr[WORDS_LOG2+1:2];  // Bits 1:0 ignored.

  // ==================================================
  // Storage
  // ==================================================

  sram_sp_be #(
    .WIDTH      (`WB_DW),
    .DEPTH_LOG2 (WORDS_LOG2)
  ) u_sram (
    .wb_clk_i (wb_clk_i),
    .en_i     (new_req),           // One access per transfer.
    .we_i     (wb_req_i.we),
    .be_i     (wb_req_i.sel),
    .adr_i    (word_idx),
    .dat_i    (wb_req_i.dat),
    .dat_o    (mem_rdata)
  );

  // ==================================================
  // Acknowledge
  // ==================================================

  // Write lands at the same edge that raises ack.
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= new_req;              // One cycle after the strobe.
    end
  end

  always_comb begin
    wb_rsp_o.ack = ack_q;
    wb_rsp_o.err = 1'b0;             // This slave never faults.
    wb_rsp_o.dat = mem_rdata;        // Valid while ack is high.
  end

  // ==================================================
  // Checks
  // ==================================================

  // Master holding stb gets at most one ack every second cycle.
  a_ack_no_back_to_back: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      ack_q |=> !ack_q
  ) else $error("wb_ram: ack high in two consecutive cycles");

  // Ack only answers a cycle seen one clock earlier.
  a_ack_after_cyc: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      ack_q |-> $past(wb_req_i.cyc)
  ) else $error("wb_ram: ack without cyc in the previous cycle");

endmodule

// File: hw/wb_decoder.sv
/*
 * Wishbone address decoder.
 * Routes each request to RAM0 or RAM1 and muxes the response back.
 * An internal default slave answers unmapped addresses with err.
 */
`include "wb_params.svh"

module wb_decoder
  import wb_pkg::*;
(
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  wb_req_t wb_req_i,        // From the master.
  output wb_rsp_t wb_rsp_o,        // To the master.
  output wb_req_t ram0_req_o,      // To RAM0.
  input  wb_rsp_t ram0_rsp_i,      // From RAM0.
  output wb_req_t ram1_req_o,      // To RAM1.
  input  wb_rsp_t ram1_rsp_i       // From RAM1.
);

  // ==================================================
  // Memory map
  // ==================================================

  localparam logic [`WB_AW-1:0] RAM0_BASE = `RAM0_BASE;
  localparam logic [`WB_AW-1:0] RAM1_BASE = `RAM1_BASE;

  // Lowest address bit above each region's byte size.
  localparam int RAM0_LSB = `RAM0_WORDS_LOG2 + 2;
  localparam int RAM1_LSB = `RAM1_WORDS_LOG2 + 2;

  logic hit0;                      // Address inside RAM0.
  logic hit1;                      // Address inside RAM1.
  logic miss;                      // Unserved strobe to a hole.
  logic err_q;                     // Default slave error register.

  // Upper bits must equal the region base.
  assign hit0 = (wb_req_i.adr[`WB_AW-1:RAM0_LSB] == RAM0_BASE[`WB_AW-1:RAM0_LSB]);
  assign hit1 = (wb_req_i.adr[`WB_AW-1:RAM1_LSB] == RAM1_BASE[`WB_AW-1:RAM1_LSB]);

  // ==================================================
  // Request path
  // ==================================================

  always_comb begin
    ram0_req_o     = wb_req_i;
    ram0_req_o.stb = wb_req_i.stb & hit0;  // Strobe only the hit region.
    ram1_req_o     = wb_req_i;
    ram1_req_o.stb = wb_req_i.stb & hit1;
  end

  // ==================================================
  // Default slave
  // ==================================================

  // Same one-cycle guard as the RAM slaves.
  assign miss = wb_req_i.cyc & wb_req_i.stb & ~hit0 & ~hit1 & ~err_q;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= miss;               // Pulse one clock after stb.
    end
  end

  // ==================================================
  // Response path
  // ==================================================

  // The master holds adr until ack or err, so the live hit selects.
  always_comb begin
    if (hit0) begin
      wb_rsp_o = ram0_rsp_i;
    end else if (hit1) begin
      wb_rsp_o = ram1_rsp_i;
    end else begin
      wb_rsp_o.ack = 1'b0;
      wb_rsp_o.err = err_q;
      wb_rsp_o.dat = '0;           // No data on a miss.
    end
  end

  // ==================================================
  // Checks
  // ==================================================

  // Regions do not overlap.
  a_one_slave_strobe: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      $onehot0({ram0_req_o.stb, ram1_req_o.stb})
  ) else $error("wb_decoder: more than one slave strobed");

  // Slave and default responses never collide at the master.
  a_ack_err_exclusive: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
      !(wb_rsp_o.ack && wb_rsp_o.err)
  ) else $error("wb_decoder: ack and err high together");

endmodule

// File: hw/wb_ram_sys.sv
/*
 * Wishbone on-chip memory subsystem.
 * One master port, an address decoder and two RAM slaves.
 */
`include "wb_params.svh"

module wb_ram_sys
  import wb_pkg::*;
(
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  input  wb_req_t wb_req_i,        // Master request.
  output wb_rsp_t wb_rsp_o         // Master response.
);

  // ==================================================
  // Slave buses
  // ==================================================

  wb_req_t ram0_req;               // Decoder to RAM0.
  wb_rsp_t ram0_rsp;               // RAM0 to decoder.
  wb_req_t ram1_req;               // Decoder to RAM1.
  wb_rsp_t ram1_rsp;               // RAM1 to decoder.

  // ==================================================
  // Decoder
  // ==================================================

  wb_decoder u_decoder (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_req_i   (wb_req_i),
    .wb_rsp_o   (wb_rsp_o),
    .ram0_req_o (ram0_req),
    .ram0_rsp_i (ram0_rsp),
    .ram1_req_o (ram1_req),
    .ram1_rsp_i (ram1_rsp)
  );

  // ==================================================
  // RAM slaves
  // ==================================================

  wb_ram #(
    .WORDS_LOG2 (`RAM0_WORDS_LOG2)   // 2 KB.
  ) u_ram0 (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_req_i (ram0_req),
    .wb_rsp_o (ram0_rsp)
  );

  wb_ram #(
    .WORDS_LOG2 (`RAM1_WORDS_LOG2)   // 1 KB.
  ) u_ram1 (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_req_i (ram1_req),
    .wb_rsp_o (ram1_rsp)
  );

endmodule

// File: verification/tb_wb_ram_sys.sv
/*
 * Testbench for the Wishbone memory subsystem.
 * Directed and random classic cycles, checked against a reference memory model.
 */
`include "wb_params.svh"

module tb_wb_ram_sys
  import wb_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // ==================================================
  // Constants and signals
  // ==================================================

  localparam int CLK_PERIOD  = 10;            // ns.
  localparam int RST_CYCLES  = 10;
  localparam int N_RANDOM    = 200;
  localparam int N_TRANSFERS = 12 + 62 + 6 + N_RANDOM;
  localparam int RESP_LIMIT  = 8;             // Cycles to wait for ack or err.
  localparam int WATCHDOG_NS = (N_TRANSFERS * 4 + RST_CYCLES + 100) * CLK_PERIOD;
  localparam int RAM0_LSB    = `RAM0_WORDS_LOG2 + 2;
  localparam int RAM1_LSB    = `RAM1_WORDS_LOG2 + 2;
  localparam logic [31:0] RAM0_BASE = `RAM0_BASE;
  localparam logic [31:0] RAM1_BASE = `RAM1_BASE;

  logic    wb_clk_i;
  logic    wb_rst_i;
  wb_req_t req;                               // Master request.
  wb_rsp_t rsp;                               // Master response.

  logic [31:0] model_dat [int];               // Reference words.
  logic [3:0]  model_val [int];               // Bytes written so far.
  logic [31:0] rng_state;

  wb_ram_sys u_dut (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_req_i (req),
    .wb_rsp_o (rsp)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
  end

  // ==================================================
  // Helpers
  // ==================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // 0 for RAM0, 1 for RAM1, 2 for a hole.
  function automatic int region_of(input logic [31:0] adr);
    if (adr[31:RAM0_LSB] == RAM0_BASE[31:RAM0_LSB]) return 0;
    if (adr[31:RAM1_LSB] == RAM1_BASE[31:RAM1_LSB]) return 1;
    return 2;
  endfunction

  function automatic int model_key(input logic [31:0] adr, input int region);
    if (region == 0) return int'(adr[RAM0_LSB-1:2]);
    return 65536 + int'(adr[RAM1_LSB-1:2]);   // RAM1 words above RAM0's.
  endfunction

  function automatic logic [31:0] byte_bits(input logic [3:0] mask);
    logic [31:0] bits;
    for (int b = 0; b < 4; b++) begin
      bits[b*8 +: 8] = {8{mask[b]}};
    end
    return bits;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  // One classic cycle; counts clocks from the strobe to ack or err.
  task automatic run_cycle(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                           input logic [31:0] dat, output wb_rsp_t got, output int cycles);
    @(posedge wb_clk_i);
    #1;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.sel = sel;
    req.dat = dat;
    cycles  = 0;
    @(negedge wb_clk_i);                       // Strobe not yet sampled.
    got = rsp;
    while (!(got.ack || got.err)) begin
      @(negedge wb_clk_i);                     // Sample mid-cycle.
      cycles++;
      got = rsp;
      assert (cycles <= RESP_LIMIT) else begin
        $display("Error: no ack or err within %0d cycles at address 0x%08h", RESP_LIMIT, adr);
        $display("Done: errors found");
        $fatal(1);
      end
    end
    @(posedge wb_clk_i);
    #1;
    req = '0;                                  // Back to idle.
  endtask

  // Runs one transfer and checks it against the model.
  task automatic access(input string name, input logic we, input logic [31:0] adr,
                        input logic [3:0] sel, input logic [31:0] dat);
    wb_rsp_t     got;
    int          cycles;
    int          region;
    int          key;
    logic [31:0] bits;
    logic [31:0] old_dat;
    logic [3:0]  old_val;
    region = region_of(adr);
    run_cycle(we, adr, sel, dat, got, cycles);
    check_eq({name, " latency"}, 32'd1, cycles);
    if (region == 2) begin
      check_eq({name, " err"}, 32'd1, got.err);
      check_eq({name, " ack"}, 32'd0, got.ack);
      check_eq({name, " miss data"}, 32'd0, got.dat);
    end else begin
      check_eq({name, " ack"}, 32'd1, got.ack);
      check_eq({name, " err"}, 32'd0, got.err);
      key     = model_key(adr, region);
      old_dat = model_dat.exists(key) ? model_dat[key] : '0;
      old_val = model_val.exists(key) ? model_val[key] : '0;
      if (we) begin
        bits           = byte_bits(sel);
        model_dat[key] = (old_dat & ~bits) | (dat & bits);  // Merge selected bytes.
        model_val[key] = old_val | sel;
      end else if (old_val != 4'h0) begin
        bits = byte_bits(old_val);                         // Known bytes only.
        check_eq({name, " read data"}, old_dat & bits, got.dat & bits);
      end
    end
  endtask

  // ==================================================
  // Tests
  // ==================================================

  task automatic test_reset();
    repeat (RST_CYCLES) begin
      @(negedge wb_clk_i);
      check_eq("reset ack", 32'd0, rsp.ack);
      check_eq("reset err", 32'd0, rsp.err);
    end
    @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);
    check_eq("post-reset ack", 32'd0, rsp.ack);
    check_eq("post-reset err", 32'd0, rsp.err);
  endtask

  task automatic test_full_word();
    logic [31:0] addrs [6];
    addrs = '{RAM0_BASE, RAM0_BASE + 32'd4 * 511, RAM0_BASE + 32'd4 * 100,
              RAM1_BASE, RAM1_BASE + 32'd4 * 255, RAM1_BASE + 32'd4 * 77};
    for (int i = 0; i < 6; i++) begin
      rng_state = xorshift32(rng_state);
      access($sformatf("full write %0d", i), 1'b1, addrs[i], 4'hF, rng_state);
    end
    for (int i = 0; i < 6; i++) begin
      access($sformatf("full read %0d", i), 1'b0, addrs[i], 4'hF, 32'h0);
    end
  endtask

  task automatic test_byte_enables();
    logic [31:0] addrs [2];
    addrs = '{RAM0_BASE + 32'd4 * 5, RAM1_BASE + 32'd4 * 9};
    for (int r = 0; r < 2; r++) begin
      rng_state = xorshift32(rng_state);
      access($sformatf("be init %0d", r), 1'b1, addrs[r], 4'hF, rng_state);
    end
    for (int s = 1; s < 16; s++) begin
      for (int r = 0; r < 2; r++) begin
        rng_state = xorshift32(rng_state);
        access($sformatf("be write sel %h ram%0d", s, r), 1'b1, addrs[r], s[3:0], rng_state);
        access($sformatf("be read sel %h ram%0d", s, r), 1'b0, addrs[r], 4'hF, 32'h0);
      end
    end
  endtask

  // Holes alias word 0 of both RAMs if decoding leaks.
  task automatic test_unmapped();
    access("hole write 0x800", 1'b1, 32'h0000_0800, 4'hF, 32'hDEAD_BEEF);
    access("hole write 0x2000", 1'b1, 32'h0000_2000, 4'hF, 32'hCAFE_F00D);
    access("hole read 0x800", 1'b0, 32'h0000_0800, 4'hF, 32'h0);
    access("hole read 0x2000", 1'b0, 32'h0000_2000, 4'hF, 32'h0);
    access("ram0 word 0 intact", 1'b0, RAM0_BASE, 4'hF, 32'h0);
    access("ram1 word 0 intact", 1'b0, RAM1_BASE, 4'hF, 32'h0);
  endtask

  // Addresses span RAM0, the gap, RAM1 and the space above it.
  task automatic test_random();
    logic [31:0] ctl;
    for (int i = 0; i < N_RANDOM; i++) begin
      rng_state = xorshift32(rng_state);
      ctl       = rng_state;
      rng_state = xorshift32(rng_state);
      access($sformatf("random %0d", i), ctl[13], {19'b0, ctl[12:0]}, ctl[17:14], rng_state);
    end
  endtask

  // ==================================================
  // Main sequence and watchdog
  // ==================================================

  initial begin
    wb_rst_i  = 1'b1;
    req       = '0;
    rng_state = 32'd80794;                     // Fixed seed.
    test_reset();
    test_full_word();
    test_byte_enables();
    test_unmapped();
    test_random();
    $display("Done: no errors");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog expired, the DUT did not respond in time");
    $display("Done: errors found");
    $fatal(1);
  end

endmodule

// File: sources.f
+incdir+include
hw/wb_pkg.sv
hw/sram_sp_be.sv
hw/wb_ram.sv
hw/wb_decoder.sv
hw/wb_ram_sys.sv
verification/tb_wb_ram_sys.sv

// File: Bender.yml
package:
  name: wb_ram_sys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/wb_pkg.sv
      - hw/sram_sp_be.sv
      - hw/wb_ram.sv
      - hw/wb_decoder.sv
      - hw/wb_ram_sys.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_wb_ram_sys.sv
